// File: tmr_mult_pkg.sv
//////////////////////////////
// tmr_mult shared definitions
// widths, operator and state encodings, fault CSR map
//////////////////////////////

package tmr_mult_pkg;

	localparam int WORD_W  = 32;
	localparam int HALF_W  = WORD_W / 2;
	localparam int N_LANES = 4; // issue lanes, the last one is the spare
	localparam int N_REPL  = 3; // multiplier replicas

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [N_REPL-1:0] replica_mask_t; // one bit per replica
	typedef logic [7:0]        err_cnt_t;
	typedef logic [11:0]       csr_addr_t;

	typedef enum logic {
		OP_MUL  = 1'b0, // low word, single cycle
		OP_MULH = 1'b1  // high word, multicycle
	} op_t;

	typedef enum logic [1:0] {
		MS_IDLE   = 2'd0,
		MS_STEP   = 2'd1,
		MS_FINISH = 2'd2
	} mult_state_t;

	// count at which a replica is treated as permanently faulty
	localparam err_cnt_t FAULT_THRESHOLD = 8'd8;

	// fault counter CSRs, one per replica
	localparam csr_addr_t CSR_ERR_CNT_0 = 12'hB10;
	localparam csr_addr_t CSR_ERR_CNT_1 = 12'hB11;
	localparam csr_addr_t CSR_ERR_CNT_2 = 12'hB12;

endpackage

// File: mult_req_if.sv
//////////////////////////////
// multiply request bundle
// one lane's request as seen by a replica
//////////////////////////////

`timescale 1ns/100ps

interface mult_req_if;

	logic                enable;
	tmr_mult_pkg::op_t   op;
	tmr_mult_pkg::word_t op_a;
	tmr_mult_pkg::word_t op_b;

	// lane selector side
	modport src (
		output enable, op, op_a, op_b
	);

	// replica side
	modport dst (
		input enable, op, op_a, op_b
	);

endinterface

// File: lane_select.sv
//////////////////////////////
// lane selector
// maps three of four issue lanes onto the replicas
//////////////////////////////

`timescale 1ns/100ps

module lane_select (
	input  logic [tmr_mult_pkg::N_LANES-1:0]                enable_i,
	input  tmr_mult_pkg::op_t [tmr_mult_pkg::N_LANES-1:0]   operator_i,
	input  tmr_mult_pkg::word_t [tmr_mult_pkg::N_LANES-1:0] op_a_i,
	input  tmr_mult_pkg::word_t [tmr_mult_pkg::N_LANES-1:0] op_b_i,
	input  tmr_mult_pkg::replica_mask_t                     sel_lane_i, // 1 = use spare lane
	mult_req_if.src                                         req_o [tmr_mult_pkg::N_REPL]
);

	// replica k sees lane k, or the spare lane when its select bit is set
	for (genvar k = 0; k < tmr_mult_pkg::N_REPL; k++) begin : g_repl
		assign req_o[k].enable = sel_lane_i[k] ? enable_i[tmr_mult_pkg::N_LANES-1]
		                                       : enable_i[k];
		assign req_o[k].op     = sel_lane_i[k] ? operator_i[tmr_mult_pkg::N_LANES-1]
		                                       : operator_i[k];
		assign req_o[k].op_a   = sel_lane_i[k] ? op_a_i[tmr_mult_pkg::N_LANES-1]
		                                       : op_a_i[k];
		assign req_o[k].op_b   = sel_lane_i[k] ? op_b_i[tmr_mult_pkg::N_LANES-1]
		                                       : op_b_i[k];
	end

endmodule

// File: mult_ctrl.sv
//////////////////////////////
// replica control FSM
// sequences MUL and MULH, holds the result on back-pressure
//////////////////////////////

`timescale 1ns/100ps

module mult_ctrl (
	input  logic                      clk,
	input  logic                      rst_i,
	mult_req_if.dst                   req_i,
	input  logic                      ex_ready_i,
	output tmr_mult_pkg::mult_state_t state_o,
	output logic                      multicycle_o,
	output logic                      ready_o
);

	tmr_mult_pkg::mult_state_t state_q;
	tmr_mult_pkg::mult_state_t state_d;
	logic                      mulh_issue;

	assign mulh_issue = req_i.enable && (req_i.op == tmr_mult_pkg::OP_MULH);

	//////////////////////////////
	// next state
	//////////////////////////////
	always_comb begin
		state_d = state_q;
		case (state_q)
			tmr_mult_pkg::MS_IDLE: begin
				if (mulh_issue)
					state_d = tmr_mult_pkg::MS_STEP; // partial product taken on this edge
			end
			tmr_mult_pkg::MS_STEP: begin
				state_d = tmr_mult_pkg::MS_FINISH;
			end
			tmr_mult_pkg::MS_FINISH: begin
				if (ex_ready_i)
					state_d = tmr_mult_pkg::MS_IDLE; // consumer took the high word
			end
			default: begin
				state_d = tmr_mult_pkg::MS_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i)
			state_q <= tmr_mult_pkg::MS_IDLE;
		else
			state_q <= state_d;
	end

	// a MULH being issued is not ready yet, MUL completes in idle
	assign ready_o = (state_q == tmr_mult_pkg::MS_FINISH) ||
	                 ((state_q == tmr_mult_pkg::MS_IDLE) && !mulh_issue);

	assign multicycle_o = (state_q != tmr_mult_pkg::MS_IDLE);
	assign state_o      = state_q;

endmodule

// File: mult_datapath.sv
//////////////////////////////
// replica datapath
// low product in one cycle, high word in two steps
//////////////////////////////

`timescale 1ns/100ps

module mult_datapath (
	input  logic                      clk,
	input  logic                      rst_i,
	mult_req_if.dst                   req_i,
	input  tmr_mult_pkg::mult_state_t state_i,
	output tmr_mult_pkg::word_t       result_o
);

	logic [tmr_mult_pkg::WORD_W+tmr_mult_pkg::HALF_W-1:0] pp_q; // op_a times low half of op_b
	logic [2*tmr_mult_pkg::WORD_W-1:0]                    full_prod;
	tmr_mult_pkg::word_t                                  hi_q;
	tmr_mult_pkg::word_t                                  lo_prod;
	logic                                                 load_pp;

	// only the low 32 bits survive the assignment
	assign lo_prod = req_i.op_a * req_i.op_b;

	assign load_pp = (state_i == tmr_mult_pkg::MS_IDLE) && req_i.enable &&
	                 (req_i.op == tmr_mult_pkg::OP_MULH);

	// second step adds the upper-half partial product
	assign full_prod = pp_q +
	                   ((req_i.op_a * req_i.op_b[tmr_mult_pkg::WORD_W-1:tmr_mult_pkg::HALF_W])
	                    << tmr_mult_pkg::HALF_W);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pp_q <= '0;
			hi_q <= '0;
		end else begin
			if (load_pp)
				pp_q <= req_i.op_a * req_i.op_b[tmr_mult_pkg::HALF_W-1:0];
			if (state_i == tmr_mult_pkg::MS_STEP)
				hi_q <= full_prod[2*tmr_mult_pkg::WORD_W-1:tmr_mult_pkg::WORD_W];
		end
	end

	// high word held for the whole finish state
	assign result_o = (state_i == tmr_mult_pkg::MS_FINISH) ? hi_q : lo_prod;

endmodule

// File: tmr_voter.sv
//////////////////////////////
// three-way majority voter
// flags the replica that disagrees
//////////////////////////////

`timescale 1ns/100ps

module tmr_voter #(
	parameter int WIDTH = 32
) (
	input  logic [WIDTH-1:0]            in0_i,
	input  logic [WIDTH-1:0]            in1_i,
	input  logic [WIDTH-1:0]            in2_i,
	output logic [WIDTH-1:0]            voted_o,
	output tmr_mult_pkg::replica_mask_t flag_o,
	output logic                        detected_o,
	output logic                        corrected_o
);

	logic [WIDTH-1:0] maj;
	logic             eq01, eq02, eq12;
	logic             all_differ;

	assign maj = (in0_i & in1_i) | (in0_i & in2_i) | (in1_i & in2_i);

	assign eq01 = (in0_i == in1_i);
	assign eq02 = (in0_i == in2_i);
	assign eq12 = (in1_i == in2_i);

	assign all_differ = !eq01 && !eq02 && !eq12; // no majority exists

	// an input is the outlier when it matches neither of the others
	assign flag_o[0] = !eq01 && !eq02;
	assign flag_o[1] = !eq01 && !eq12;
	assign flag_o[2] = !eq02 && !eq12;

	assign voted_o     = all_differ ? in0_i : maj; // fall back to replica 0
	assign detected_o  = |flag_o;
	assign corrected_o = detected_o && !all_differ;

endmodule

// File: vote_stage.sv
//////////////////////////////
// vote stage
// votes replica outputs, bypass mux, error summary
//////////////////////////////

`timescale 1ns/100ps

module vote_stage (
	input  tmr_mult_pkg::word_t [tmr_mult_pkg::N_REPL-1:0] res_i,
	input  logic [tmr_mult_pkg::N_REPL-1:0]                mc_i,
	input  logic [tmr_mult_pkg::N_REPL-1:0]                rdy_i,
	input  logic [1:0]                                     sel_bypass_i,
	output tmr_mult_pkg::word_t                            result_o,
	output logic                                           multicycle_o,
	output logic                                           ready_o,
	output logic                                           err_detected_o,
	output logic                                           err_corrected_o,
	output tmr_mult_pkg::replica_mask_t                    flag_o
);

	tmr_mult_pkg::word_t         res_voted;
	logic                        mc_voted, rdy_voted;
	tmr_mult_pkg::replica_mask_t res_flag, mc_flag, rdy_flag;
	logic                        res_det, mc_det, rdy_det;
	logic                        res_cor, mc_cor, rdy_cor;

	tmr_voter #(.WIDTH(tmr_mult_pkg::WORD_W)) res_voter_i (
		.in0_i(res_i[0]), .in1_i(res_i[1]), .in2_i(res_i[2]),
		.voted_o(res_voted), .flag_o(res_flag),
		.detected_o(res_det), .corrected_o(res_cor)
	);

	tmr_voter #(.WIDTH(1)) mc_voter_i (
		.in0_i(mc_i[0]), .in1_i(mc_i[1]), .in2_i(mc_i[2]),
		.voted_o(mc_voted), .flag_o(mc_flag),
		.detected_o(mc_det), .corrected_o(mc_cor)
	);

	tmr_voter #(.WIDTH(1)) rdy_voter_i (
		.in0_i(rdy_i[0]), .in1_i(rdy_i[1]), .in2_i(rdy_i[2]),
		.voted_o(rdy_voted), .flag_o(rdy_flag),
		.detected_o(rdy_det), .corrected_o(rdy_cor)
	);

	//////////////////////////////
	// bypass, 0 = voted, k+1 = replica k
	//////////////////////////////
	always_comb begin
		case (sel_bypass_i)
			2'd1:    {result_o, multicycle_o, ready_o} = {res_i[0], mc_i[0], rdy_i[0]};
			2'd2:    {result_o, multicycle_o, ready_o} = {res_i[1], mc_i[1], rdy_i[1]};
			2'd3:    {result_o, multicycle_o, ready_o} = {res_i[2], mc_i[2], rdy_i[2]};
			default: {result_o, multicycle_o, ready_o} = {res_voted, mc_voted, rdy_voted};
		endcase
	end

	// errors are reported in bypass mode too
	assign err_detected_o  = res_det || mc_det || rdy_det;
	assign err_corrected_o = res_cor || mc_cor || rdy_cor;
	assign flag_o          = res_flag | mc_flag | rdy_flag;

endmodule

// File: fault_counters.sv
//////////////////////////////
// replica fault counters
// saturating disagreement counts, CSR access, fault flags
//////////////////////////////

`timescale 1ns/100ps

module fault_counters (
	input  logic                        clk,
	input  logic                        rst_i,
	input  tmr_mult_pkg::replica_mask_t flag_i,
	input  tmr_mult_pkg::csr_addr_t     csr_addr_i,
	input  logic                        csr_re_i,
	input  logic                        csr_we_i,
	input  tmr_mult_pkg::word_t         csr_wdata_i,
	output tmr_mult_pkg::word_t         csr_rdata_o,
	output tmr_mult_pkg::replica_mask_t permanent_faulty_o
);

	tmr_mult_pkg::err_cnt_t      cnt_q    [tmr_mult_pkg::N_REPL];
	tmr_mult_pkg::csr_addr_t     cnt_addr [tmr_mult_pkg::N_REPL];
	tmr_mult_pkg::replica_mask_t hit;

	assign cnt_addr[0] = tmr_mult_pkg::CSR_ERR_CNT_0;
	assign cnt_addr[1] = tmr_mult_pkg::CSR_ERR_CNT_1;
	assign cnt_addr[2] = tmr_mult_pkg::CSR_ERR_CNT_2;

	//////////////////////////////
	// counters
	//////////////////////////////
	for (genvar k = 0; k < tmr_mult_pkg::N_REPL; k++) begin : g_cnt
		assign hit[k] = (csr_addr_i == cnt_addr[k]);

		always_ff @(posedge clk) begin
			if (rst_i)
				cnt_q[k] <= '0;
			else if (csr_we_i && hit[k])
				cnt_q[k] <= tmr_mult_pkg::err_cnt_t'(csr_wdata_i); // write beats increment
			else if (flag_i[k] && !(&cnt_q[k]))
				cnt_q[k] <= cnt_q[k] + 1'b1; // stops at 255
		end

		assign permanent_faulty_o[k] = (cnt_q[k] >= tmr_mult_pkg::FAULT_THRESHOLD);
	end

	// read port, zero when nothing matches
	always_comb begin
		csr_rdata_o = '0;
		for (int k = 0; k < tmr_mult_pkg::N_REPL; k++) begin
			if (csr_re_i && hit[k])
				csr_rdata_o = tmr_mult_pkg::word_t'(cnt_q[k]);
		end
	end

endmodule

// File: tmr_mult.sv
//////////////////////////////
// fault-tolerant multiplier
// three voted replicas fed from four lanes, with
// bypass and per-replica fault counters
//////////////////////////////

`timescale 1ns/100ps

module tmr_mult (
	input  logic                                            clk,
	input  logic                                            rst_i,

	// issue lanes
	input  logic [tmr_mult_pkg::N_LANES-1:0]                enable_i,
	input  tmr_mult_pkg::op_t [tmr_mult_pkg::N_LANES-1:0]   operator_i,
	input  tmr_mult_pkg::word_t [tmr_mult_pkg::N_LANES-1:0] op_a_i,
	input  tmr_mult_pkg::word_t [tmr_mult_pkg::N_LANES-1:0] op_b_i,

	input  tmr_mult_pkg::replica_mask_t                     sel_lane_i,
	input  logic [1:0]                                      sel_bypass_i,
	input  logic                                            ex_ready_i,

	output tmr_mult_pkg::word_t                             result_o,
	output logic                                            multicycle_o,
	output logic                                            ready_o,

	output logic                                            err_detected_o,
	output logic                                            err_corrected_o,
	output tmr_mult_pkg::replica_mask_t                     permanent_faulty_o,

	// fault counter CSRs
	input  tmr_mult_pkg::csr_addr_t                         csr_addr_i,
	input  logic                                            csr_re_i,
	input  logic                                            csr_we_i,
	input  tmr_mult_pkg::word_t                             csr_wdata_i,
	output tmr_mult_pkg::word_t                             csr_rdata_o
);

	tmr_mult_pkg::word_t [tmr_mult_pkg::N_REPL-1:0] repl_res;
	logic [tmr_mult_pkg::N_REPL-1:0]                repl_mc;
	logic [tmr_mult_pkg::N_REPL-1:0]                repl_rdy;
	tmr_mult_pkg::mult_state_t                      repl_state [tmr_mult_pkg::N_REPL];
	tmr_mult_pkg::replica_mask_t                    vote_flag; // OR of all voter flags

	mult_req_if req_if [tmr_mult_pkg::N_REPL] ();

	lane_select lane_select_i (
		.enable_i   (enable_i),
		.operator_i (operator_i),
		.op_a_i     (op_a_i),
		.op_b_i     (op_b_i),
		.sel_lane_i (sel_lane_i),
		.req_o      (req_if)
	);

	//////////////////////////////
	// replicas
	//////////////////////////////
	for (genvar k = 0; k < tmr_mult_pkg::N_REPL; k++) begin : g_repl
		mult_ctrl mult_ctrl_i (
			.clk          (clk),
			.rst_i        (rst_i),
			.req_i        (req_if[k]),
			.ex_ready_i   (ex_ready_i),
			.state_o      (repl_state[k]),
			.multicycle_o (repl_mc[k]),
			.ready_o      (repl_rdy[k])
		);

		mult_datapath mult_datapath_i (
			.clk      (clk),
			.rst_i    (rst_i),
			.req_i    (req_if[k]),
			.state_i  (repl_state[k]),
			.result_o (repl_res[k])
		);
	end

	vote_stage vote_stage_i (
		.res_i           (repl_res),
		.mc_i            (repl_mc),
		.rdy_i           (repl_rdy),
		.sel_bypass_i    (sel_bypass_i),
		.result_o        (result_o),
		.multicycle_o    (multicycle_o),
		.ready_o         (ready_o),
		.err_detected_o  (err_detected_o),
		.err_corrected_o (err_corrected_o),
		.flag_o          (vote_flag)
	);

	fault_counters fault_counters_i (
		.clk                (clk),
		.rst_i              (rst_i),
		.flag_i             (vote_flag),
		.csr_addr_i         (csr_addr_i),
		.csr_re_i           (csr_re_i),
		.csr_we_i           (csr_we_i),
		.csr_wdata_i        (csr_wdata_i),
		.csr_rdata_o        (csr_rdata_o),
		.permanent_faulty_o (permanent_faulty_o)
	);

endmodule

// File: tb_clock_gen.sv
//////////////////////////////
// testbench clock and reset
//////////////////////////////

`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #20 clk_o = ~clk_o; // 40 ns period
	end

	// reset held for 8 cycles, released on a falling edge
	initial begin
		rst_o = 1'b1;
		repeat (8) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule

// File: tmr_mult_props.sv
//////////////////////////////
// tmr_mult checks
// concurrent assertions on the top level ports
//////////////////////////////

`timescale 1ns/100ps

module tmr_mult_props (
	input logic                                            clk,
	input logic                                            rst_i,
	input logic [tmr_mult_pkg::N_LANES-1:0]                enable_i,
	input tmr_mult_pkg::op_t [tmr_mult_pkg::N_LANES-1:0]   operator_i,
	input tmr_mult_pkg::word_t [tmr_mult_pkg::N_LANES-1:0] op_a_i,
	input tmr_mult_pkg::word_t [tmr_mult_pkg::N_LANES-1:0] op_b_i,
	input tmr_mult_pkg::replica_mask_t                     sel_lane_i,
	input logic [1:0]                                      sel_bypass_i,
	input logic                                            ex_ready_i,
	input tmr_mult_pkg::word_t                             result_o,
	input logic                                            multicycle_o,
	input logic                                            ready_o,
	input logic                                            err_detected_o,
	input logic                                            err_corrected_o,
	input tmr_mult_pkg::replica_mask_t                     permanent_faulty_o,
	input tmr_mult_pkg::csr_addr_t                         csr_addr_i,
	input logic                                            csr_re_i,
	input logic                                            csr_we_i,
	input tmr_mult_pkg::word_t                             csr_wdata_i,
	input tmr_mult_pkg::word_t                             csr_rdata_o
);

	logic [63:0]                 prod [3]; // full product seen by each replica
	tmr_mult_pkg::word_t         lo [3];
	logic [2:0]                  is_mul;
	logic [2:0]                  is_mulh;
	logic [2:0]                  odd_one; // replica k matches neither of the others
	logic [2:0]                  csr_hit;
	logic                        voted;
	logic                        mul_idle;
	logic                        lo_agree;
	logic                        lane1_out;
	logic                        mulh_issue;
	tmr_mult_pkg::mult_state_t   exp_state; // where the replicas should be
	tmr_mult_pkg::word_t         exp_hi;
	tmr_mult_pkg::err_cnt_t      exp_cnt [3]; // expected count per replica
	tmr_mult_pkg::replica_mask_t exp_perm;
	tmr_mult_pkg::word_t         exp_rdata;
	int                          fail_cnt = 0;

	task automatic note_failure(input string msg);
		fail_cnt++;
		$error("%s", msg);
	endtask

	// request each replica sees after lane selection
	always_comb begin : eff_req
		int lane;
		for (int k = 0; k < tmr_mult_pkg::N_REPL; k++) begin
			lane       = sel_lane_i[k] ? tmr_mult_pkg::N_LANES - 1 : k;
			prod[k]    = {32'd0, op_a_i[lane]} * {32'd0, op_b_i[lane]};
			lo[k]      = prod[k][31:0];
			is_mul[k]  = enable_i[lane] && (operator_i[lane] == tmr_mult_pkg::OP_MUL);
			is_mulh[k] = enable_i[lane] && (operator_i[lane] == tmr_mult_pkg::OP_MULH);
		end
		for (int k = 0; k < tmr_mult_pkg::N_REPL; k++)
			odd_one[k] = (lo[k] != lo[(k + 1) % tmr_mult_pkg::N_REPL]) &&
			             (lo[k] != lo[(k + 2) % tmr_mult_pkg::N_REPL]);
	end

	// CSR view and fault flags from the expected counts
	always_comb begin
		exp_rdata = '0;
		for (int k = 0; k < tmr_mult_pkg::N_REPL; k++) begin
			csr_hit[k]  = (csr_addr_i == tmr_mult_pkg::CSR_ERR_CNT_0 + k);
			exp_perm[k] = (exp_cnt[k] >= tmr_mult_pkg::FAULT_THRESHOLD);
			if (csr_re_i && csr_hit[k])
				exp_rdata = {24'd0, exp_cnt[k]};
		end
	end

	assign voted      = (sel_bypass_i == 2'd0);
	assign mul_idle   = (&is_mul) && (exp_state == tmr_mult_pkg::MS_IDLE) && voted;
	assign lo_agree   = (lo[0] == lo[1]) && (lo[1] == lo[2]);
	assign lane1_out  = (lo[0] == lo[2]) && (lo[1] != lo[0]); // replica 1 alone disagrees
	assign mulh_issue = (&is_mulh) && (exp_state == tmr_mult_pkg::MS_IDLE) &&
	                    (prod[0] == prod[1]) && (prod[1] == prod[2]);

	//////////////////////////////
	// expected sequence, high word and counters
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (rst_i) begin
			exp_state <= tmr_mult_pkg::MS_IDLE;
			exp_hi    <= '0;
			for (int k = 0; k < tmr_mult_pkg::N_REPL; k++)
				exp_cnt[k] <= '0;
		end else begin
			case (exp_state)
				tmr_mult_pkg::MS_IDLE: begin
					if (mulh_issue) begin
						exp_state <= tmr_mult_pkg::MS_STEP;
						exp_hi    <= prod[0][63:32];
					end
				end
				tmr_mult_pkg::MS_STEP: begin
					exp_state <= tmr_mult_pkg::MS_FINISH;
				end
				tmr_mult_pkg::MS_FINISH: begin
					if (ex_ready_i)
						exp_state <= tmr_mult_pkg::MS_IDLE; // consumer took it
				end
				default: begin
					exp_state <= tmr_mult_pkg::MS_IDLE;
				end
			endcase
			for (int k = 0; k < tmr_mult_pkg::N_REPL; k++) begin
				if (csr_we_i && csr_hit[k])
					exp_cnt[k] <= csr_wdata_i[7:0];
				else if (odd_one[k] && (exp_cnt[k] != 8'hFF))
					exp_cnt[k] <= exp_cnt[k] + 8'd1;
			end
		end
	end

	// majority of replicas 0 and 2 decides the result
	a_mul_result: assert property (@(posedge clk) disable iff (rst_i)
		mul_idle && (lo[0] == lo[2]) |-> result_o == lo[0])
		else note_failure($sformatf("FAIL %0t result_o exp %h got %h",
		                            $time, $sampled(lo[0]), $sampled(result_o)));

	a_mul_status: assert property (@(posedge clk) disable iff (rst_i)
		mul_idle && lo_agree |-> ready_o && !multicycle_o && !err_detected_o)
		else note_failure($sformatf(
			"FAIL %0t ready_o/multicycle_o/err_detected_o exp 1/0/0 got %b/%b/%b",
			$time, $sampled(ready_o), $sampled(multicycle_o), $sampled(err_detected_o)));

	a_mask_flags: assert property (@(posedge clk) disable iff (rst_i)
		mul_idle && lane1_out |-> err_detected_o && err_corrected_o)
		else note_failure($sformatf("FAIL %0t err_detected_o/err_corrected_o exp 1/1 got %b/%b",
		                            $time, $sampled(err_detected_o), $sampled(err_corrected_o)));

	a_mulh_seq: assert property (@(posedge clk) disable iff (rst_i)
		mulh_issue |=> (multicycle_o && !ready_o) ##1 (multicycle_o && ready_o))
		else note_failure($sformatf("multicycle_o and ready_o out of step after MULH at %0t",
		                            $time));

	a_mulh_result: assert property (@(posedge clk) disable iff (rst_i)
		(exp_state == tmr_mult_pkg::MS_FINISH) && voted |-> result_o == exp_hi)
		else note_failure($sformatf("FAIL %0t result_o exp %h got %h",
		                            $time, $sampled(exp_hi), $sampled(result_o)));

	// finish state must hold while the consumer stalls
	a_mulh_hold: assert property (@(posedge clk) disable iff (rst_i)
		(exp_state == tmr_mult_pkg::MS_FINISH) && !ex_ready_i && voted |=>
		multicycle_o && ready_o && $stable(result_o))
		else note_failure($sformatf("high word not held under back-pressure at %0t", $time));

	a_bypass: assert property (@(posedge clk) disable iff (rst_i)
		(&is_mul) && (exp_state == tmr_mult_pkg::MS_IDLE) && !voted |->
		result_o == lo[sel_bypass_i - 2'd1])
		else note_failure($sformatf("FAIL %0t result_o exp %h got %h", $time,
		                            $sampled(lo[sel_bypass_i - 2'd1]), $sampled(result_o)));

	a_csr_read: assert property (@(posedge clk) disable iff (rst_i)
		csr_rdata_o == exp_rdata)
		else note_failure($sformatf("FAIL %0t csr_rdata_o exp %h got %h",
		                            $time, $sampled(exp_rdata), $sampled(csr_rdata_o)));

	a_perm: assert property (@(posedge clk) disable iff (rst_i)
		permanent_faulty_o == exp_perm)
		else note_failure($sformatf("FAIL %0t permanent_faulty_o exp %b got %b", $time,
		                            $sampled(exp_perm), $sampled(permanent_faulty_o)));

endmodule

bind tmr_mult tmr_mult_props props_i (.*);

// File: tb_tmr_mult.sv
//////////////////////////////
// tmr_mult testbench
// walks the lanes through MUL, MULH, faults, bypass and CSRs
//////////////////////////////

`timescale 1ns/100ps

module tb_tmr_mult;

	logic                                            clk;
	logic                                            rst_i;
	logic [tmr_mult_pkg::N_LANES-1:0]                enable_i;
	tmr_mult_pkg::op_t [tmr_mult_pkg::N_LANES-1:0]   operator_i;
	tmr_mult_pkg::word_t [tmr_mult_pkg::N_LANES-1:0] op_a_i;
	tmr_mult_pkg::word_t [tmr_mult_pkg::N_LANES-1:0] op_b_i;
	tmr_mult_pkg::replica_mask_t                     sel_lane_i;
	logic [1:0]                                      sel_bypass_i;
	logic                                            ex_ready_i;
	tmr_mult_pkg::word_t                             result_o;
	logic                                            multicycle_o;
	logic                                            ready_o;
	logic                                            err_detected_o;
	logic                                            err_corrected_o;
	tmr_mult_pkg::replica_mask_t                     permanent_faulty_o;
	tmr_mult_pkg::csr_addr_t                         csr_addr_i;
	logic                                            csr_re_i;
	logic                                            csr_we_i;
	tmr_mult_pkg::word_t                             csr_wdata_i;
	tmr_mult_pkg::word_t                             csr_rdata_o;
	integer                                          seed;

	tb_clock_gen clock_gen_i (.clk_o(clk), .rst_o(rst_i));

	tmr_mult tmr_mult_i (.*);

	task automatic give_up(input string what);
		$display("Errors found");
		$fatal(1, "timeout, %s", what);
	endtask

	// same random request on all four lanes
	task automatic drive_random(input logic en, input tmr_mult_pkg::op_t op);
		tmr_mult_pkg::word_t a;
		tmr_mult_pkg::word_t b;
		a = $random(seed);
		b = $random(seed);
		for (int k = 0; k < tmr_mult_pkg::N_LANES; k++) begin
			enable_i[k]   = en;
			operator_i[k] = op;
			op_a_i[k]     = a;
			op_b_i[k]     = b;
		end
	endtask

	task automatic issue_mul(input logic corrupt_lane1);
		drive_random(1'b1, tmr_mult_pkg::OP_MUL);
		if (corrupt_lane1) begin
			op_a_i[1] = $random(seed); // lane 1 disagrees
			op_b_i[1] = $random(seed);
		end
		@(negedge clk);
	endtask

	// first failing assertion ends the run
	always @(negedge clk) begin
		if (tmr_mult_i.props_i.fail_cnt != 0) begin
			$display("Errors found");
			$fatal(1, "assertion failure in the DUT checks");
		end
	end

	initial begin
		int n;
		seed = 32'h3321;
		drive_random(1'b0, tmr_mult_pkg::OP_MUL);
		sel_lane_i   = '0;
		sel_bypass_i = 2'd0;
		ex_ready_i   = 1'b1;
		csr_addr_i   = tmr_mult_pkg::CSR_ERR_CNT_1;
		csr_re_i     = 1'b0;
		csr_we_i     = 1'b0;
		csr_wdata_i  = '0;

		n = 0;
		while (rst_i) begin
			@(posedge clk);
			n++;
			if (n > 20)
				give_up("reset never released");
		end
		@(negedge clk);

		csr_re_i = 1'b1; // count is still 0
		@(negedge clk);
		csr_re_i = 1'b0;

		repeat (4) issue_mul(1'b0);

		//////////////////////////////
		// MULH under back-pressure
		//////////////////////////////
		ex_ready_i = 1'b0;
		drive_random(1'b1, tmr_mult_pkg::OP_MULH);
		@(negedge clk);
		n = 0;
		while (!ready_o) begin
			@(negedge clk);
			n++;
			if (n > 8)
				give_up("ready_o never rose after MULH");
		end
		repeat (3) @(negedge clk);
		ex_ready_i = 1'b1;
		drive_random(1'b1, tmr_mult_pkg::OP_MUL);
		@(negedge clk);

		repeat (4) issue_mul(1'b1); // single fault masked

		sel_lane_i = 3'b010; // spare lane replaces lane 1
		repeat (4) issue_mul(1'b1);
		sel_lane_i = '0;

		for (int k = 1; k < 4; k++) begin
			sel_bypass_i = 2'(k);
			issue_mul(1'b1);
		end
		sel_bypass_i = 2'd0;

		// keep replica 1 disagreeing until it is flagged
		n = 0;
		while (!permanent_faulty_o[1]) begin
			issue_mul(1'b1);
			n++;
			if (n > 40)
				give_up("permanent_faulty_o[1] never set");
		end
		issue_mul(1'b0);
		csr_re_i = 1'b1;
		@(negedge clk);
		csr_re_i    = 1'b0;
		csr_we_i    = 1'b1; // clear with the lanes agreeing
		csr_wdata_i = '0;
		@(negedge clk);
		csr_we_i = 1'b0;
		repeat (2) @(negedge clk);

		if (tmr_mult_i.props_i.fail_cnt == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1, "assertion failure in the DUT checks");
		end
	end

endmodule

// File: tmr_mult.f
tmr_mult_pkg.sv
mult_req_if.sv
lane_select.sv
mult_ctrl.sv
mult_datapath.sv
tmr_voter.sv
vote_stage.sv
fault_counters.sv
tmr_mult.sv
tb_clock_gen.sv
tmr_mult_props.sv
tb_tmr_mult.sv
